//--- Bender.yml
package:
  name: lsu_l1d

sources:
  - common/lsu_pkg.sv
  - common/l1d_pkg.sv
  - common/bus_req_if.sv
  - l1d/l1d_region_cfg.sv
  - l1d/l1d_cache.sv
  - hdl/bus_credit_port.sv
  - lsu_core/lsu_core.sv
  - hdl/lsu_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/tb_checker.sv
      - test/tb_lsu.sv

//--- common/bus_req_if.sv
`timescale 1ns/1ps
`default_nettype none

interface bus_req_if;
  import lsu_pkg::*;

  // request from the core
  logic req_valid;
  logic is_write;
  word_t addr;
  word_t wdata;
  strb_t strb;

  // credit available, so the request goes out this cycle
  logic can_issue;

  // response back to the core
  logic rsp_valid;
  word_t rsp_data;

  modport core (
    output req_valid, is_write, addr, wdata, strb,
    input can_issue, rsp_valid, rsp_data
  );

  modport port (
    input req_valid, is_write, addr, wdata, strb,
    output can_issue, rsp_valid, rsp_data
  );

endinterface

`default_nettype wire

//--- common/l1d_pkg.sv
`default_nettype none

package l1d_pkg;

  // 16 direct-mapped lines of one word each
  localparam int l1d_off_len = 2;
  localparam int l1d_idx_len = 4;
  localparam int l1d_tag_len = 32 - l1d_idx_len - l1d_off_len;
  localparam int l1d_lines = 2 ** l1d_idx_len;

  typedef logic [l1d_idx_len-1:0] l1d_idx_t;
  typedef logic [l1d_tag_len-1:0] l1d_tag_t;

  // cacheable ranges after reset, base inclusive and limit exclusive
  localparam logic [31:0] region_default_base0 = 32'h8000_0000;
  localparam logic [31:0] region_default_limit0 = 32'h8040_0000;
  localparam logic [31:0] region_default_base1 = 32'ha000_0000;
  localparam logic [31:0] region_default_limit1 = 32'hc000_0000;

endpackage

`default_nettype wire

//--- common/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  // data and address width
  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;

  // byte lane strobe, one bit per byte of a word
  typedef logic [xlen/8-1:0] strb_t;

  // memory operation codes
  // bit 3 marks a store, bit 2 a zero-extended load, bits 1:0 the size
  typedef enum logic [3:0] {
    lb  = 4'b0000,
    lh  = 4'b0001,
    lw  = 4'b0010,
    lbu = 4'b0100,
    lhu = 4'b0101,
    sb  = 4'b1000,
    sh  = 4'b1001,
    sw  = 4'b1010
  } mem_op_e;

  // credits held by the bus port after reset
  localparam int bus_credits = 2;
  localparam int credit_w = $clog2(bus_credits + 1);

  typedef logic [credit_w-1:0] credit_t;

endpackage

`default_nettype wire

//--- hdl/bus_credit_port.sv
`timescale 1ns/1ps
`default_nettype none

module bus_credit_port (
  input  logic clock,
  input  logic reset,
  bus_req_if.port bus,
  output logic bus_valid,
  output logic bus_write,
  output logic [lsu_pkg::xlen-1:0] bus_addr,
  output logic [lsu_pkg::xlen-1:0] bus_wdata,
  output lsu_pkg::strb_t bus_strb,
  input  logic bus_credit_return,
  input  logic bus_rsp_valid,
  input  logic [lsu_pkg::xlen-1:0] bus_rsp_data
);
  import lsu_pkg::*;

  credit_t credit_q;

  assign bus.can_issue = (credit_q != '0);
  // gated again here so no request leaves without a credit
  assign bus_valid = bus.req_valid && bus.can_issue;
  assign bus_write = bus.is_write;
  assign bus_addr = bus.addr;
  assign bus_wdata = bus.wdata;
  assign bus_strb = bus.strb;

  assign bus.rsp_valid = bus_rsp_valid;
  assign bus.rsp_data = bus_rsp_data;

  always_ff @(posedge clock) begin
    if (reset) begin
      credit_q <= credit_t'(bus_credits);
    end else begin
      case ({bus_valid, bus_credit_return})
        2'b10: credit_q <= credit_q - 1'b1;
        2'b01: credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  // a wrap below zero also lands above the limit
  a_credit_range: assert property (
    @(posedge clock) disable iff (reset) credit_q <= credit_t'(bus_credits)
  ) else $error("credit count out of range: %0d", credit_q);

endmodule

`default_nettype wire

//--- hdl/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
  input  logic clock,
  input  logic reset,
  // execute side
  input  logic req_valid,
  input  lsu_pkg::mem_op_e req_op,
  input  logic [lsu_pkg::xlen-1:0] req_addr,
  input  logic [lsu_pkg::xlen-1:0] req_wdata,
  output logic req_ready,
  output logic done,
  output logic [lsu_pkg::xlen-1:0] load_data,
  // system bus
  output logic bus_valid,
  output logic bus_write,
  output logic [lsu_pkg::xlen-1:0] bus_addr,
  output logic [lsu_pkg::xlen-1:0] bus_wdata,
  output lsu_pkg::strb_t bus_strb,
  input  logic bus_credit_return,
  input  logic bus_rsp_valid,
  input  logic [lsu_pkg::xlen-1:0] bus_rsp_data,
  // region config
  input  logic cfg_wen,
  input  logic [1:0] cfg_sel,
  input  logic [lsu_pkg::xlen-1:0] cfg_wdata
);
  import lsu_pkg::*;

  word_t lookup_addr;
  word_t hit_data;
  logic lookup_en;
  logic hit;
  logic cacheable;
  logic fill_en;
  logic inval_en;

  bus_req_if u_bus ();

  lsu_core u_core (
    .clock       (clock),
    .reset       (reset),
    .req_valid   (req_valid),
    .req_op      (req_op),
    .req_addr    (req_addr),
    .req_wdata   (req_wdata),
    .req_ready   (req_ready),
    .done        (done),
    .load_data   (load_data),
    .bus         (u_bus.core),
    .lookup_addr (lookup_addr),
    .lookup_en   (lookup_en),
    .hit         (hit),
    .hit_data    (hit_data),
    .cacheable   (cacheable),
    .fill_en     (fill_en),
    .inval_en    (inval_en)
  );

  // fills take the word straight off the response path
  l1d_cache u_cache (
    .clock       (clock),
    .reset       (reset),
    .lookup_addr (lookup_addr),
    .lookup_en   (lookup_en),
    .fill_en     (fill_en),
    .fill_data   (u_bus.rsp_data),
    .inval_en    (inval_en),
    .hit         (hit),
    .hit_data    (hit_data)
  );

  l1d_region_cfg u_region (
    .clock     (clock),
    .reset     (reset),
    .cfg_wen   (cfg_wen),
    .cfg_sel   (cfg_sel),
    .cfg_wdata (cfg_wdata),
    .addr      (lookup_addr),
    .cacheable (cacheable)
  );

  bus_credit_port u_port (
    .clock             (clock),
    .reset             (reset),
    .bus               (u_bus.port),
    .bus_valid         (bus_valid),
    .bus_write         (bus_write),
    .bus_addr          (bus_addr),
    .bus_wdata         (bus_wdata),
    .bus_strb          (bus_strb),
    .bus_credit_return (bus_credit_return),
    .bus_rsp_valid     (bus_rsp_valid),
    .bus_rsp_data      (bus_rsp_data)
  );

endmodule

`default_nettype wire

//--- l1d/l1d_cache.sv
`timescale 1ns/1ps
`default_nettype none

module l1d_cache (
  input  logic clock,
  input  logic reset,
  input  logic [lsu_pkg::xlen-1:0] lookup_addr,
  input  logic lookup_en,
  input  logic fill_en,
  input  logic [lsu_pkg::xlen-1:0] fill_data,
  input  logic inval_en,
  output logic hit,
  output logic [lsu_pkg::xlen-1:0] hit_data
);
  import lsu_pkg::*;
  import l1d_pkg::*;

  word_t data_q [l1d_lines];
  l1d_tag_t tag_q [l1d_lines];
  logic [l1d_lines-1:0] valid_q;

  l1d_idx_t idx;
  l1d_tag_t tag;
  logic tag_match;

  // word offset below the index, tag above it
  assign idx = lookup_addr[l1d_idx_len+l1d_off_len-1:l1d_off_len];
  assign tag = lookup_addr[xlen-1:l1d_idx_len+l1d_off_len];

  assign tag_match = valid_q[idx] && (tag_q[idx] == tag);
  assign hit = lookup_en && tag_match;
  assign hit_data = data_q[idx];

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
    end else if (fill_en) begin
      valid_q[idx] <= 1'b1;
    end else if (inval_en && tag_match) begin
      // another address sharing the line keeps its copy
      valid_q[idx] <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (fill_en) begin
      data_q[idx] <= fill_data;
      tag_q[idx] <= tag;
    end
  end

  a_fill_inval_excl: assert property (
    @(posedge clock) disable iff (reset) !(fill_en && inval_en)
  ) else $error("fill and invalidate in the same cycle");

endmodule

`default_nettype wire

//--- l1d/l1d_region_cfg.sv
`timescale 1ns/1ps
`default_nettype none

module l1d_region_cfg (
  input  logic clock,
  input  logic reset,
  input  logic cfg_wen,
  input  logic [1:0] cfg_sel,
  input  logic [lsu_pkg::xlen-1:0] cfg_wdata,
  input  logic [lsu_pkg::xlen-1:0] addr,
  output logic cacheable
);
  import lsu_pkg::*;
  import l1d_pkg::*;

  // base0, limit0, base1, limit1 in cfg_sel order
  word_t region_q [4];
  logic in_region0;
  logic in_region1;

  always_ff @(posedge clock) begin
    if (reset) begin
      region_q[0] <= region_default_base0;
      region_q[1] <= region_default_limit0;
      region_q[2] <= region_default_base1;
      region_q[3] <= region_default_limit1;
    end else if (cfg_wen) begin
      region_q[cfg_sel] <= cfg_wdata;
    end
  end

  assign in_region0 = (addr >= region_q[0]) && (addr < region_q[1]);
  assign in_region1 = (addr >= region_q[2]) && (addr < region_q[3]);
  assign cacheable = in_region0 || in_region1;

endmodule

`default_nettype wire

//--- lsu_core/lsu_core.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_core (
  input  logic clock,
  input  logic reset,
  input  logic req_valid,
  input  lsu_pkg::mem_op_e req_op,
  input  logic [lsu_pkg::xlen-1:0] req_addr,
  input  logic [lsu_pkg::xlen-1:0] req_wdata,
  output logic req_ready,
  output logic done,
  output logic [lsu_pkg::xlen-1:0] load_data,
  bus_req_if.core bus,
  output logic [lsu_pkg::xlen-1:0] lookup_addr,
  output logic lookup_en,
  input  logic hit,
  input  logic [lsu_pkg::xlen-1:0] hit_data,
  input  logic cacheable,
  output logic fill_en,
  output logic inval_en
);
  import lsu_pkg::*;

  typedef enum logic [1:0] {st_idle, st_lookup, st_issue, st_wait} state_e;

  state_e state_q;
  mem_op_e op_q;
  word_t addr_q;
  word_t wdata_q;
  word_t rsp_q;
  logic done_q;
  logic is_store;
  logic load_hit;
  logic [4:0] shamt;
  word_t raw_word;
  word_t shifted;
  strb_t strb_base;

  assign is_store = (op_q == sb) || (op_q == sh) || (op_q == sw);
  // a line left over from an old region setting must not count
  assign load_hit = !is_store && hit && cacheable;
  assign shamt = {addr_q[1:0], 3'b000};

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= st_idle;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        st_idle: begin
          if (req_valid) begin
            state_q <= st_lookup;
          end
        end
        st_lookup: begin
          if (load_hit) begin
            state_q <= st_idle;
          end else if (bus.can_issue) begin
            state_q <= st_wait;
          end else begin
            state_q <= st_issue;
          end
        end
        // hold here until a credit shows up
        st_issue: begin
          if (bus.can_issue) begin
            state_q <= st_wait;
          end
        end
        st_wait: begin
          if (bus.rsp_valid) begin
            state_q <= st_idle;
            done_q <= 1'b1;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (req_valid && req_ready) begin
      op_q <= req_op;
      addr_q <= req_addr;
      wdata_q <= req_wdata;
    end
    if (state_q == st_wait && bus.rsp_valid) begin
      rsp_q <= bus.rsp_data;
    end
  end

  // held low through reset
  assign req_ready = (state_q == st_idle) && !reset;
  assign lookup_addr = addr_q;
  assign lookup_en = (state_q == st_lookup);
  // the cache checks the tag itself
  assign inval_en = lookup_en && is_store;
  assign fill_en = (state_q == st_wait) && bus.rsp_valid && !is_store && cacheable;
  assign done = done_q || (lookup_en && load_hit);

  assign bus.req_valid = ((lookup_en && !load_hit) || state_q == st_issue) && bus.can_issue;
  assign bus.is_write = is_store;
  assign bus.addr = addr_q;
  assign bus.wdata = wdata_q << shamt;
  assign bus.strb = strb_base << addr_q[1:0];

  always_comb begin
    case (op_q)
      lb, lbu, sb: strb_base = 4'b0001;
      lh, lhu, sh: strb_base = 4'b0011;
      default: strb_base = 4'b1111;
    endcase
  end

  // hit data in lookup, otherwise the registered bus word
  assign raw_word = lookup_en ? hit_data : rsp_q;
  assign shifted = raw_word >> shamt;

  always_comb begin
    case (op_q)
      lb: load_data = {{(xlen-8){shifted[7]}}, shifted[7:0]};
      lbu: load_data = {{(xlen-8){1'b0}}, shifted[7:0]};
      lh: load_data = {{(xlen-16){shifted[15]}}, shifted[15:0]};
      lhu: load_data = {{(xlen-16){1'b0}}, shifted[15:0]};
      default: load_data = shifted;
    endcase
  end

  // idle with nothing offered must stay quiet on the bus next cycle
  a_no_req_idle: assert property (
    @(posedge clock) disable iff (reset)
    (state_q == st_idle && !req_valid) |=> !bus.req_valid
  ) else $error("bus request raised with no request accepted");

endmodule

`default_nettype wire

//--- tb.f
common/lsu_pkg.sv
common/l1d_pkg.sv
common/bus_req_if.sv
l1d/l1d_region_cfg.sv
l1d/l1d_cache.sv
hdl/bus_credit_port.sv
lsu_core/lsu_core.sv
hdl/lsu_top.sv
test/tb_clock.sv
test/tb_checker.sv
test/tb_lsu.sv

//--- test/lsu_vectors.hex
// test op addr wdata expected bus, all hex; bus 0 hit, 1 bus request, 2 with credits held back
// op 0 lb, 1 lh, 2 lw, 4 lbu, 5 lhu, 8 sb, 9 sh, a sw, c config write with the select in addr
01 2 80000310 00000000 5a5a5a9e 1
02 0 80000310 00000000 ffffff9e 0
03 4 80000310 00000000 0000009e 0
04 0 80000311 00000000 0000005a 0
05 4 80000312 00000000 0000005a 0
06 5 80000312 00000000 00005a5a 0
07 1 80000310 00000000 00005a9e 0
08 a 00000040 89abcdef 00000000 1
09 0 00000041 00000000 ffffffcd 1
0a 4 00000043 00000000 00000089 1
0b 0 00000043 00000000 ffffff89 1
0c 1 00000042 00000000 ffff89ab 1
0d 5 00000042 00000000 000089ab 1
0e 1 00000040 00000000 ffffcdef 1
0f 2 00000040 00000000 89abcdef 1
10 9 80000312 0000beef 00000000 1
11 2 80000310 00000000 beef5a9e 1
12 1 80000312 00000000 ffffbeef 0
13 8 80000311 00000077 00000000 1
14 4 80000311 00000000 00000077 1
15 2 a0000020 00000000 5a5a5a52 1
16 2 a0000020 00000000 5a5a5a52 0
17 c 00000000 80001000 00000000 0
18 2 80000310 00000000 beef779e 1
19 2 80000310 00000000 beef779e 1
1a 2 00000100 00000000 5a5a5a1a 2
1b 2 00000104 00000000 5a5a5a1b 2
1c 2 00000108 00000000 5a5a5a18 2
1d 2 0000010c 00000000 5a5a5a19 2
1e 2 00000100 00000000 5a5a5a1a 2

//--- test/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
  input  logic clock,
  input  logic reset,
  input  logic req_valid,
  input  logic req_ready,
  input  lsu_pkg::mem_op_e req_op,
  input  logic [31:0] req_addr,
  input  logic [31:0] req_wdata,
  input  logic done,
  input  logic [31:0] load_data,
  input  logic bus_valid,
  input  logic bus_write,
  input  logic [31:0] bus_addr,
  input  logic [31:0] bus_wdata,
  input  logic [3:0] bus_strb,
  input  logic bus_credit_return,
  input  logic [7:0] test_id,
  input  logic [31:0] exp_data,
  input  logic [1:0] exp_bus,
  output int error_count,
  output int fail_count
);
  import lsu_pkg::*;

  int errors = 0;
  int fails = 0;
  int credits;
  int cycle;
  int accept_cycle;
  int bus_reqs;
  int errors_at_start;
  logic active;
  mem_op_e op_q;
  logic [31:0] addr_q;
  logic [31:0] wdata_q;
  logic [31:0] exp_q;
  logic [1:0] bus_q;
  logic [7:0] id_q;

  assign error_count = errors;
  assign fail_count = fails;

  function automatic logic is_store(input mem_op_e op);
    return (op == sb) || (op == sh) || (op == sw);
  endfunction

  // 1, 2 or 4 bytes, moved up to the byte the address points at
  function automatic logic [3:0] store_strobe(input mem_op_e op, input logic [1:0] offset);
    logic [3:0] lanes;
    case (op)
      sb: lanes = 4'b0001;
      sh: lanes = 4'b0011;
      default: lanes = 4'b1111;
    endcase
    return lanes << offset;
  endfunction

  function automatic logic [31:0] lane_mask(input logic [3:0] strb);
    logic [31:0] mask;
    for (int i = 0; i < 4; i++) begin
      mask[8*i +: 8] = {8{strb[i]}};
    end
    return mask;
  endfunction

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
    $display("** Error test %0h: %s got 0x%h, expected 0x%h", id_q, name, got, expected);
    errors++;
  endtask

  task automatic report_failure(input string what);
    $display("test %0h: %s", id_q, what);
    errors++;
  endtask

  task automatic check_bus_request();
    logic [3:0] strb;
    logic [31:0] mask;
    logic [31:0] exp_wdata;
    if (credits == 0) begin
      report_failure("bus_valid rose while no credit was held");
    end
    if (!active) begin
      report_failure("bus request with no operation in progress");
    end else begin
      bus_reqs++;
      if (bus_q == 2'd0) begin
        report_failure("unexpected bus request, the load should hit the cache");
      end
      if (bus_reqs > 1) begin
        report_failure("more than one bus request for one operation");
      end
      if (bus_addr !== addr_q) begin
        report_value("bus_addr", bus_addr, addr_q);
      end
      if (bus_write !== is_store(op_q)) begin
        report_value("bus_write", 32'(bus_write), 32'(is_store(op_q)));
      end
      if (is_store(op_q)) begin
        strb = store_strobe(op_q, addr_q[1:0]);
        mask = lane_mask(strb);
        exp_wdata = wdata_q << {addr_q[1:0], 3'b000};
        if (bus_strb !== strb) begin
          report_value("bus_strb", 32'(bus_strb), 32'(strb));
        end
        // only the strobed lanes carry data
        if ((bus_wdata & mask) !== (exp_wdata & mask)) begin
          report_value("bus_wdata", bus_wdata & mask, exp_wdata & mask);
        end
      end
    end
  endtask

  task automatic finish_test();
    int latency;
    latency = cycle - accept_cycle;
    if (!active) begin
      report_failure("done rose with no operation in progress");
    end else begin
      if (!is_store(op_q) && load_data !== exp_q) begin
        report_value("load_data", load_data, exp_q);
      end
      if (bus_q == 2'd0 && latency != 1) begin
        report_failure($sformatf("done came %0d cycles after acceptance, not 1", latency));
      end
      if (bus_q != 2'd0 && bus_reqs == 0) begin
        report_failure("no bus request was made, one was expected");
      end
      if (errors == errors_at_start) begin
        $display("test %0h: %s 0x%h ok, %0d cycles", id_q, op_q.name(), addr_q, latency);
      end else begin
        fails++;
        $display("test %0h: %s 0x%h failed", id_q, op_q.name(), addr_q);
      end
      active = 1'b0;
    end
  endtask

  // outputs are settled by the falling edge
  always @(negedge clock) begin
    if (reset) begin
      credits = bus_credits;
      cycle = 0;
      active = 1'b0;
      if (req_ready === 1'b1 || done === 1'b1 || bus_valid === 1'b1) begin
        $display("req_ready, done or bus_valid was high during reset");
        errors++;
      end
    end else begin
      cycle++;
      if (bus_valid) begin
        check_bus_request();
      end
      credits = credits - int'(bus_valid) + int'(bus_credit_return);
      // busy until done
      if (active && !done && req_ready) begin
        report_failure("req_ready high before done");
      end
      if (done) begin
        finish_test();
      end
      if (req_valid && req_ready) begin
        active = 1'b1;
        accept_cycle = cycle;
        bus_reqs = 0;
        errors_at_start = errors;
        op_q = req_op;
        addr_q = req_addr;
        wdata_q = req_wdata;
        exp_q = exp_data;
        bus_q = exp_bus;
        id_q = test_id;
      end
    end
  end

endmodule

`default_nettype wire

//--- test/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int period_ns = 20,
  parameter int reset_cycles = 4
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever begin
      #(period_ns / 2);
      clock = ~clock;
    end
  end

  // released just after a rising edge, like the rest of the stimulus
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clock);
    #1;
    reset = 1'b0;
  end

endmodule

`default_nettype wire

//--- test/tb_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lsu;
  import lsu_pkg::*;

  localparam int max_lines = 64;
  localparam int fields = 6;
  localparam int cycles_per_line = 20;
  // extra credit delay while credits are held back
  localparam int hold_delay = 16;

  logic clock;
  logic reset;
  logic req_valid;
  mem_op_e req_op;
  logic [31:0] req_addr;
  logic [31:0] req_wdata;
  logic req_ready;
  logic done;
  logic [31:0] load_data;
  logic bus_valid;
  logic bus_write;
  logic [31:0] bus_addr;
  logic [31:0] bus_wdata;
  logic [3:0] bus_strb;
  logic bus_credit_return;
  logic bus_rsp_valid;
  logic [31:0] bus_rsp_data;
  logic cfg_wen;
  logic [1:0] cfg_sel;
  logic [31:0] cfg_wdata;

  // current test, seen by the checker and the memory model
  logic [7:0] test_id;
  logic [31:0] exp_data;
  logic [1:0] exp_bus;

  logic [31:0] vectors [max_lines*fields];
  logic [31:0] mem [256];
  logic [31:0] rng_state;
  int n_lines;
  int cycle_count;
  int cycle_limit = 0;
  int error_count;
  int fail_count;

  tb_clock #(.period_ns(20), .reset_cycles(4)) u_clock (.clock(clock), .reset(reset));

  lsu_top u_dut (
    .clock             (clock),
    .reset             (reset),
    .req_valid         (req_valid),
    .req_op            (req_op),
    .req_addr          (req_addr),
    .req_wdata         (req_wdata),
    .req_ready         (req_ready),
    .done              (done),
    .load_data         (load_data),
    .bus_valid         (bus_valid),
    .bus_write         (bus_write),
    .bus_addr          (bus_addr),
    .bus_wdata         (bus_wdata),
    .bus_strb          (bus_strb),
    .bus_credit_return (bus_credit_return),
    .bus_rsp_valid     (bus_rsp_valid),
    .bus_rsp_data      (bus_rsp_data),
    .cfg_wen           (cfg_wen),
    .cfg_sel           (cfg_sel),
    .cfg_wdata         (cfg_wdata)
  );

  tb_checker u_checker (
    .clock             (clock),
    .reset             (reset),
    .req_valid         (req_valid),
    .req_ready         (req_ready),
    .req_op            (req_op),
    .req_addr          (req_addr),
    .req_wdata         (req_wdata),
    .done              (done),
    .load_data         (load_data),
    .bus_valid         (bus_valid),
    .bus_write         (bus_write),
    .bus_addr          (bus_addr),
    .bus_wdata         (bus_wdata),
    .bus_strb          (bus_strb),
    .bus_credit_return (bus_credit_return),
    .test_id           (test_id),
    .exp_data          (exp_data),
    .exp_bus           (exp_bus),
    .error_count       (error_count),
    .fail_count        (fail_count)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // 1 to 4 cycles
  function automatic int random_delay();
    rng_state = xorshift32(rng_state);
    return 1 + int'(rng_state % 4);
  endfunction

  // memory model, one request at a time
  initial begin : bus_model
    int rsp_left;
    int model_cycle;
    int credit_due [$];
    logic [31:0] rsp_word;
    logic [7:0] idx;
    rsp_left = 0;
    model_cycle = 0;
    rsp_word = '0;
    rng_state = 32'd54;
    bus_credit_return = 1'b0;
    bus_rsp_valid = 1'b0;
    bus_rsp_data = '0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'(i) ^ 32'h5a5a_5a5a;
    end
    forever begin
      @(negedge clock);
      if (!reset && bus_valid) begin
        idx = bus_addr[9:2];
        if (bus_write) begin
          for (int b = 0; b < 4; b++) begin
            if (bus_strb[b]) begin
              mem[idx][8*b +: 8] = bus_wdata[8*b +: 8];
            end
          end
          rsp_word = '0;
        end else begin
          rsp_word = mem[idx];
        end
        rsp_left = random_delay();
        credit_due.push_back(model_cycle + random_delay() + ((exp_bus == 2'd2) ? hold_delay : 0));
      end
      @(posedge clock);
      #1;
      model_cycle++;
      bus_rsp_valid = 1'b0;
      bus_credit_return = 1'b0;
      if (rsp_left > 0) begin
        rsp_left--;
        if (rsp_left == 0) begin
          bus_rsp_valid = 1'b1;
          bus_rsp_data = rsp_word;
        end
      end
      // at most one credit per cycle
      if (credit_due.size() > 0 && credit_due[0] <= model_cycle) begin
        bus_credit_return = 1'b1;
        void'(credit_due.pop_front());
      end
    end
  end

  task automatic run_access(input logic [7:0] id, input logic [3:0] op,
                            input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [31:0] expected, input logic [1:0] bus_flag);
    @(posedge clock);
    #1;
    test_id = id;
    exp_data = expected;
    exp_bus = bus_flag;
    req_op = mem_op_e'(op);
    req_addr = addr;
    req_wdata = wdata;
    req_valid = 1'b1;
    @(negedge clock);
    while (!req_ready) begin
      @(negedge clock);
    end
    @(posedge clock);
    #1;
    req_valid = 1'b0;
    @(negedge clock);
    while (!done) begin
      @(negedge clock);
    end
  endtask

  task automatic write_config(input logic [7:0] id, input logic [1:0] sel,
                              input logic [31:0] value);
    @(posedge clock);
    #1;
    test_id = id;
    cfg_wen = 1'b1;
    cfg_sel = sel;
    cfg_wdata = value;
    @(posedge clock);
    #1;
    cfg_wen = 1'b0;
    $display("test %0h: config write, register %0d set to 0x%h", id, sel, value);
  endtask

  initial begin : driver
    int base;
    req_valid = 1'b0;
    req_op = lw;
    req_addr = '0;
    req_wdata = '0;
    cfg_wen = 1'b0;
    cfg_sel = '0;
    cfg_wdata = '0;
    test_id = '0;
    exp_data = '0;
    exp_bus = '0;
    for (int i = 0; i < max_lines * fields; i++) begin
      vectors[i] = '0;
    end
    $readmemh("test/lsu_vectors.hex", vectors);
    // a zero test number ends the list
    n_lines = 0;
    while (n_lines < max_lines && vectors[n_lines * fields] != '0) begin
      n_lines++;
    end
    cycle_limit = n_lines * cycles_per_line;
    if (n_lines == 0) begin
      $display("no vectors read from test/lsu_vectors.hex");
    end
    @(negedge reset);
    for (int n = 0; n < n_lines; n++) begin
      base = n * fields;
      if (vectors[base + 1][3:0] == 4'hc) begin
        write_config(vectors[base][7:0], vectors[base + 2][1:0], vectors[base + 3]);
      end else begin
        run_access(vectors[base][7:0], vectors[base + 1][3:0], vectors[base + 2],
                   vectors[base + 3], vectors[base + 4], vectors[base + 5][1:0]);
      end
    end
    repeat (2) @(posedge clock);
    $display("%0d tests run, %0d failed, %0d errors", n_lines, fail_count, error_count);
    if (n_lines > 0 && error_count == 0 && fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin : watchdog
    cycle_count = 0;
    wait (cycle_limit > 0);
    while (cycle_count < cycle_limit) begin
      @(negedge clock);
      cycle_count++;
    end
    $display("timeout after %0d cycles, test %0h never raised done", cycle_count, test_id);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire
